/* hw/memPkg.sv */
`default_nettype none

package memPkg;

    // byte address into the RAM
    localparam int AddrWidth = 17;

    // one data word or one instruction
    localparam int DataWidth = 32;

    // one RAM location
    localparam int ByteWidth = 8;

    // byte count of an access
    localparam int LenWidth = 3;

    localparam logic [LenWidth-1:0] LenByte = 3'd1;
    localparam logic [LenWidth-1:0] LenHalf = 3'd2;
    localparam logic [LenWidth-1:0] LenWord = 3'd4;

    // one byte per address, whole address space populated
    localparam int RamDepth = 2 ** AddrWidth;

    // Idle   waiting for a request; the valid cycle already drives byte 0
    // Issue  stepping the address through the access
    // Drain  last read byte arrives one cycle after its address
    typedef enum logic [1:0] {
        Idle  = 2'd0,
        Issue = 2'd1,
        Drain = 2'd2
    } SeqState;

endpackage

`default_nettype wire

/* hw/memReqIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface memReqIf;

    logic                           valid;
    logic                           write;
    logic [memPkg::AddrWidth-1:0]   addr;
    logic [memPkg::LenWidth-1:0]    len;
    logic [memPkg::DataWidth-1:0]   wdata;

    // completion side
    logic                           busy;
    logic                           done;
    logic [memPkg::DataWidth-1:0]   rdata;

    modport arbiter (
        output valid, write, addr, len, wdata,
        input  busy, done, rdata
    );

    modport sequencer (
        input  valid, write, addr, len, wdata,
        output busy, done, rdata
    );

endinterface

`default_nettype wire

/* hw/ramBusIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface ramBusIf;

    logic                           we;
    logic [memPkg::AddrWidth-1:0]   addr;
    logic [memPkg::ByteWidth-1:0]   wdata;
    logic [memPkg::ByteWidth-1:0]   rdata;

    modport master (
        output we, addr, wdata,
        input  rdata
    );

    modport ram (
        input  we, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* hw/memArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           fetchEn,
    input  logic [memPkg::AddrWidth-1:0]   fetchAddr,

    input  logic                           dataEn,
    input  logic                           dataWrite,
    input  logic [memPkg::LenWidth-1:0]    dataLen,
    input  logic [memPkg::AddrWidth-1:0]   dataAddr,
    input  logic [memPkg::DataWidth-1:0]   dataWdata,

    output logic                           fetchDone,
    output logic [memPkg::DataWidth-1:0]   fetchInst,
    output logic                           dataDone,
    output logic [memPkg::DataWidth-1:0]   dataRdata,

    memReqIf.arbiter                       req
);

    logic seqFree;
    logic accept;
    logic ownerData;

    // busy only rises the cycle after valid, so valid blocks too
    assign seqFree = !req.valid && !req.busy && !req.done;
    assign accept  = seqFree && (dataEn || fetchEn);

    always_ff @(posedge clk) begin
        if (rst) begin
            req.valid <= 1'b0;
            ownerData <= 1'b0;
        end else begin
            req.valid <= accept;
            if (accept) begin
                // data port wins a tie
                ownerData <= dataEn;
            end
        end
    end

    // request fields stay put until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            if (dataEn) begin
                req.write <= dataWrite;
                req.addr  <= dataAddr;
                req.len   <= dataLen;
                req.wdata <= dataWdata;
            end else begin
                req.write <= 1'b0;
                req.addr  <= fetchAddr;
                req.len   <= memPkg::LenWord;
                req.wdata <= '0;
            end
        end
    end

    // completion goes to the owner only
    assign fetchDone = req.done && !ownerData;
    assign dataDone  = req.done && ownerData;

    assign fetchInst = ownerData ? '0 : req.rdata;
    assign dataRdata = ownerData ? req.rdata : '0;

endmodule

`default_nettype wire

/* hw/byteSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module byteSequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  logic            ioBufferFull,
    memReqIf.sequencer      req,
    ramBusIf.master         ram
);

    memPkg::SeqState                state;
    logic [memPkg::LenWidth-1:0]    cnt;
    logic                           stall;
    logic                           issuing;
    logic                           lastByte;

    // read capture, one cycle behind the address
    logic                           capLive;
    logic [memPkg::LenWidth-1:0]    capIdx;
    logic [memPkg::DataWidth-1:0]   assembly;
    logic [memPkg::DataWidth-1:0]   filled;

    assign stall = !rdy || ioBufferFull;

    // the valid cycle already presents byte 0
    assign issuing  = (state == memPkg::Idle && req.valid) || state == memPkg::Issue;
    assign lastByte = (cnt + memPkg::LenWidth'(1)) == req.len;

    assign req.busy = state != memPkg::Idle;

    // cnt is frozen on a stall and in drain, so the address holds
    assign ram.addr  = req.addr + memPkg::AddrWidth'(cnt);
    assign ram.wdata = req.wdata[cnt * memPkg::ByteWidth +: memPkg::ByteWidth];
    assign ram.we    = issuing && req.write && !stall;

    // rdata always belongs to last cycle's address; a stall repeats the same byte
    always_comb begin
        filled = assembly;
        if (capLive) begin
            filled[capIdx * memPkg::ByteWidth +: memPkg::ByteWidth] = ram.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= memPkg::Idle;
            cnt      <= '0;
            capLive  <= 1'b0;
            req.done <= 1'b0;
        end else begin
            req.done <= 1'b0;
            capLive  <= (issuing && !req.write) || state == memPkg::Drain;

            if (issuing) begin
                if (stall) begin
                    // request recorded, nothing advances
                    state <= memPkg::Issue;
                end else if (!lastByte) begin
                    state <= memPkg::Issue;
                    cnt   <= cnt + memPkg::LenWidth'(1);
                end else if (req.write) begin
                    // last byte written on this edge
                    state    <= memPkg::Idle;
                    cnt      <= '0;
                    req.done <= 1'b1;
                end else begin
                    state <= memPkg::Drain;
                end
            end else if (state == memPkg::Drain && !stall) begin
                state    <= memPkg::Idle;
                cnt      <= '0;
                req.done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        capIdx <= cnt;

        // cleared on accept so short loads come out zero-extended
        if (state == memPkg::Idle && req.valid) begin
            assembly <= '0;
        end else begin
            assembly <= filled;
        end

        if (state == memPkg::Drain && !stall) begin
            req.rdata <= filled;
        end
    end

endmodule

`default_nettype wire

/* hw/byteRam.sv */
`timescale 1ns/1ps
`default_nettype none

module byteRam (
    input  logic    clk,
    ramBusIf.ram    ram
);

    logic [memPkg::ByteWidth-1:0] mem [memPkg::RamDepth];

    // read is registered every cycle; same-address write returns old data
    always_ff @(posedge clk) begin
        if (ram.we) begin
            mem[ram.addr] <= ram.wdata;
        end
        ram.rdata <= mem[ram.addr];
    end

endmodule

`default_nettype wire

/* hw/memSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rdy,
    input  logic                           ioBufferFull,

    // instruction fetch
    input  logic                           fetchEn,
    input  logic [memPkg::AddrWidth-1:0]   fetchAddr,
    output logic                           fetchDone,
    output logic [memPkg::DataWidth-1:0]   fetchInst,

    // load/store
    input  logic                           dataEn,
    input  logic                           dataWrite,
    input  logic [memPkg::LenWidth-1:0]    dataLen,
    input  logic [memPkg::AddrWidth-1:0]   dataAddr,
    input  logic [memPkg::DataWidth-1:0]   dataWdata,
    output logic                           dataDone,
    output logic [memPkg::DataWidth-1:0]   dataRdata
);

    memReqIf reqBus ();
    ramBusIf ramBus ();

    memArbiter uArbiter (
        .clk        (clk),
        .rst        (rst),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .dataEn     (dataEn),
        .dataWrite  (dataWrite),
        .dataLen    (dataLen),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .dataDone   (dataDone),
        .dataRdata  (dataRdata),
        .req        (reqBus.arbiter)
    );

    byteSequencer uSequencer (
        .clk            (clk),
        .rst            (rst),
        .rdy            (rdy),
        .ioBufferFull   (ioBufferFull),
        .req            (reqBus.sequencer),
        .ram            (ramBus.master)
    );

    byteRam uRam (
        .clk    (clk),
        .ram    (ramBus.ram)
    );

endmodule

`default_nettype wire

/* sim/memSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;

    logic                           clk;
    logic                           rst;
    logic                           rdy;
    logic                           ioBufferFull;

    logic                           fetchEn;
    logic [memPkg::AddrWidth-1:0]   fetchAddr;
    logic                           fetchDone;
    logic [memPkg::DataWidth-1:0]   fetchInst;

    logic                           dataEn;
    logic                           dataWrite;
    logic [memPkg::LenWidth-1:0]    dataLen;
    logic [memPkg::AddrWidth-1:0]   dataAddr;
    logic [memPkg::DataWidth-1:0]   dataWdata;
    logic                           dataDone;
    logic [memPkg::DataWidth-1:0]   dataRdata;

    // one entry per vector line
    int                             vecKind[$];
    logic                           vecWrite[$];
    logic [memPkg::LenWidth-1:0]    vecLen[$];
    logic [memPkg::AddrWidth-1:0]   vecAddr[$];
    logic [memPkg::DataWidth-1:0]   vecWdata[$];
    logic [memPkg::DataWidth-1:0]   vecExpect[$];
    int                             vecCount;
    logic                           loaded;

    logic [31:0]                    rngState;

    // byte image of what the stores so far have written
    logic [memPkg::ByteWidth-1:0]   shadow[int];

    memSubsystem u_dut (
        .clk            (clk),
        .rst            (rst),
        .rdy            (rdy),
        .ioBufferFull   (ioBufferFull),
        .fetchEn        (fetchEn),
        .fetchAddr      (fetchAddr),
        .fetchDone      (fetchDone),
        .fetchInst      (fetchInst),
        .dataEn         (dataEn),
        .dataWrite      (dataWrite),
        .dataLen        (dataLen),
        .dataAddr       (dataAddr),
        .dataWdata      (dataWdata),
        .dataDone       (dataDone),
        .dataRdata      (dataRdata)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic reportFail(input string what);
        $display("error: %s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("FAILED %s expected %h got %h", name, expected, actual);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic loadVectors();
        int fd;
        int n;
        int kind;
        logic [31:0] w;
        logic [31:0] l;
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] ex;
        logic [8*160-1:0] lineBuf;
        fd = $fopen("sim/memTestdata.txt", "r");
        assert (fd != 0) else reportFail("could not open sim/memTestdata.txt");
        while ($fgets(lineBuf, fd) != 0) begin
            // comment and blank lines do not parse
            n = $sscanf(lineBuf, "%d %h %h %h %h %h", kind, w, l, a, wd, ex);
            if (n == 6) begin
                vecKind.push_back(kind);
                vecAddr.push_back(memPkg::AddrWidth'(a));
                vecExpect.push_back(ex);
                if (kind == 1) begin
                    vecWrite.push_back(1'b0);
                    vecLen.push_back(memPkg::LenWord);
                    vecWdata.push_back('0);
                end else begin
                    vecWrite.push_back(w != 0);
                    vecLen.push_back(memPkg::LenWidth'(l));
                    vecWdata.push_back(wd);
                end
            end
        end
        $fclose(fd);
    endtask

    // stores update the image, loads cross-check the data file against it
    task automatic applyToModel(input int idx);
        logic [31:0] model;
        int len;
        int base;
        len = int'(vecLen[idx]);
        base = int'(vecAddr[idx]);
        model = '0;
        for (int b = 0; b < len; b++) begin
            if (vecWrite[idx]) begin
                shadow[base + b] = vecWdata[idx][b * memPkg::ByteWidth +: memPkg::ByteWidth];
            end else begin
                assert (shadow.exists(base + b))
                    else reportFail("test data reads a byte that was never stored");
                model[b * memPkg::ByteWidth +: memPkg::ByteWidth] = shadow[base + b];
            end
        end
        if (!vecWrite[idx]) begin
            assert (model === vecExpect[idx])
                else reportValue("vecExpect", model, vecExpect[idx]);
        end
    endtask

    // di or fi is -1 when that port stays idle
    task automatic runAccess(input int di, input int fi);
        logic dataBusy;
        logic fetchBusy;
        logic stalled;
        int dataClean;
        int fetchClean;
        int fetchWait;
        int dataNeed;
        int fetchNeed;
        dataBusy = di >= 0;
        fetchBusy = fi >= 0;
        dataClean = 0;
        fetchClean = 0;
        fetchWait = 0;
        dataNeed = 0;
        fetchNeed = int'(memPkg::LenWord) + 1;
        if (dataBusy) begin
            applyToModel(di);
            dataNeed = vecWrite[di] ? int'(vecLen[di]) : int'(vecLen[di]) + 1;
            dataWrite = vecWrite[di];
            dataLen = vecLen[di];
            dataAddr = vecAddr[di];
            dataWdata = vecWdata[di];
            dataEn = 1'b1;
        end
        if (fetchBusy) begin
            applyToModel(fi);
            fetchAddr = vecAddr[fi];
            fetchEn = 1'b1;
        end
        @(posedge clk);
        #1;
        while (dataBusy || fetchBusy) begin
            @(negedge clk);
            stalled = !rdy || ioBufferFull;
            assert (!(dataDone && fetchDone)) else reportFail("both done strobes in one cycle");
            assert (!dataDone || dataBusy) else reportFail("dataDone with no data access pending");
            assert (!fetchDone || fetchBusy) else reportFail("fetchDone with no fetch pending");
            if (dataDone) begin
                assert (dataClean == dataNeed)
                    else reportFail("dataDone at the wrong unstalled cycle count");
                if (!vecWrite[di]) begin
                    assert (dataRdata === vecExpect[di])
                        else reportValue("dataRdata", vecExpect[di], dataRdata);
                end
                dataBusy = 1'b0;
                // fetch is accepted at the end of the next cycle
                fetchClean = 0;
                fetchWait = 2;
            end
            if (fetchDone) begin
                assert (!dataBusy) else reportFail("fetch finished ahead of the data access");
                assert (fetchClean == fetchNeed)
                    else reportFail("fetchDone at the wrong unstalled cycle count");
                assert (fetchInst === vecExpect[fi])
                    else reportValue("fetchInst", vecExpect[fi], fetchInst);
                fetchBusy = 1'b0;
            end
            if (!stalled) begin
                dataClean++;
            end
            if (fetchWait > 0) begin
                fetchWait--;
            end else if (!stalled) begin
                fetchClean++;
            end
            @(posedge clk);
            #1;
            if (!dataBusy) begin
                dataEn = 1'b0;
            end
            if (!fetchBusy) begin
                fetchEn = 1'b0;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // random stalls, split between the two stall inputs
    initial begin
        rngState = 32'h5276387c;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rngState = xorshift(rngState);
            rdy = 1'b1;
            ioBufferFull = 1'b0;
            if (rngState[1:0] == 2'b00) begin
                if (rngState[2]) begin
                    rdy = 1'b0;
                end else begin
                    ioBufferFull = 1'b1;
                end
            end
        end
    end

    initial begin
        wait (loaded === 1'b1);
        repeat ((vecCount + 1) * 60) @(posedge clk);
        $display("error: watchdog expired, an access never completed");
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    end

    initial begin
        int i;
        rst = 1'b1;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataWrite = 1'b0;
        dataLen = '0;
        dataAddr = '0;
        dataWdata = '0;
        loaded = 1'b0;
        loadVectors();
        vecCount = vecKind.size();
        assert (vecCount > 0) else reportFail("no test vectors found");
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        i = 0;
        while (i < vecCount) begin
            if (vecKind[i] == 2) begin
                assert (i + 1 < vecCount && vecKind[i + 1] == 1)
                    else reportFail("a paired data line is not followed by a fetch line");
                runAccess(i, i + 1);
                i += 2;
            end else if (vecKind[i] == 1) begin
                runAccess(-1, i);
                i++;
            end else begin
                runAccess(i, -1);
                i++;
            end
        end
        // nothing pending, so the done strobes must stay quiet
        repeat (4) begin
            @(negedge clk);
            assert (!dataDone && !fetchDone) else reportFail("done strobe while idle");
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/memTestdata.txt */
# kind write len addr wdata expect; kind is decimal, the rest hex, expect used on reads only
# kind 0 data, 1 fetch, 2 data raised in the same cycle as the fetch on the next line
0 1 4 00100 deadbeef 00000000
0 0 4 00100 00000000 deadbeef
0 0 1 00100 00000000 000000ef
0 0 1 00101 00000000 000000be
0 0 1 00102 00000000 000000ad
0 0 1 00103 00000000 000000de
0 0 2 00100 00000000 0000beef
0 0 2 00102 00000000 0000dead
0 1 4 00200 11223344 00000000
0 1 2 00200 a5a5c3d2 00000000
0 0 2 00200 00000000 0000c3d2
0 0 4 00200 00000000 1122c3d2
0 1 1 00300 ffffff7e 00000000
0 0 1 00300 00000000 0000007e
0 1 4 00400 cafef00d 00000000
0 1 1 00402 00000099 00000000
0 0 4 00400 00000000 ca99f00d
0 0 2 00401 00000000 000099f0
1 0 4 00100 00000000 deadbeef
1 0 4 00400 00000000 ca99f00d
0 1 4 1fffc 13579bdf 00000000
1 0 4 1fffc 00000000 13579bdf
2 0 4 00200 00000000 1122c3d2
1 0 4 00100 00000000 deadbeef
2 1 4 00500 89abcdef 00000000
1 0 4 00400 00000000 ca99f00d
0 0 4 00500 00000000 89abcdef
2 0 1 00503 00000000 00000089
1 0 4 00500 00000000 89abcdef
2 1 4 00600 0badf00d 00000000
1 0 4 00600 00000000 0badf00d
0 1 2 00602 0000abcd 00000000
0 0 4 00600 00000000 abcdf00d
1 0 4 00600 00000000 abcdf00d

/* tb.f */
hw/memPkg.sv
hw/memReqIf.sv
hw/ramBusIf.sv
hw/memArbiter.sv
hw/byteSequencer.sv
hw/byteRam.sv
hw/memSubsystem.sv
sim/memSubsystemTb.sv

/* Makefile */
SRCS := hw/memPkg.sv hw/memReqIf.sv hw/ramBusIf.sv hw/memArbiter.sv \
        hw/byteSequencer.sv hw/byteRam.sv hw/memSubsystem.sv sim/memSubsystemTb.sv

.PHONY: all run clean

all: run

obj_dir/VmemSubsystemTb: tb.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module memSubsystemTb -f tb.f

sim.log: obj_dir/VmemSubsystemTb sim/memTestdata.txt
	-./obj_dir/VmemSubsystemTb > sim.log 2>&1

run: obj_dir/VmemSubsystemTb
	-./obj_dir/VmemSubsystemTb > sim.log 2>&1
	@cat sim.log
	@grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
